/* source/rv_pkg.sv */
// rv_pkg: widths, value types, opcode constants, operation enum, decoded and memory-request structs
package rv_pkg;

  localparam int XLEN = 64;
  localparam int ILEN = 32;

  typedef logic [XLEN-1:0] xlen_t;  // register, data or address
  typedef logic [ILEN-1:0] inst_t;  // one instruction word
  typedef logic [4:0]      reg_idx_t;
  typedef logic [7:0]      strb_t;  // byte enables of one doubleword

  localparam xlen_t RESET_PC = 64'h0;

  // major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  localparam inst_t INST_EBREAK = 32'h00100073;  // the only system encoding taken

  typedef enum logic [4:0] {
    op_illegal, op_lui, op_auipc, op_jal, op_jalr, op_bne,
    op_lw, op_lbu, op_ld, op_sd,
    op_addi, op_sltiu, op_addiw, op_add, op_sub, op_addw, op_srai,
    op_ebreak
  } op_e;

  typedef struct packed {
    op_e        op;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    xlen_t      imm;    // sign-extended, format already chosen
    logic [5:0] shamt;
  } decoded_t;

  typedef struct packed {
    xlen_t addr;   // doubleword aligned
    xlen_t wdata;
    strb_t wstrb;
    logic  write;
  } mem_req_t;

  typedef enum logic [2:0] {
    st_fetch, st_execute, st_memory, st_writeback, st_halt
  } ctrl_state_e;

endpackage

/* source/inst_decode.sv */
// inst_decode: combinational RV64 decoder for the supported subset, immediates and register fields
module inst_decode import rv_pkg::*; (
  input  inst_t    inst,
  output decoded_t dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // every format extends from bit 31
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec       = '0;
    dec.op    = op_illegal;
    dec.rd    = inst[11:7];
    dec.rs1   = inst[19:15];
    dec.rs2   = inst[24:20];
    dec.shamt = inst[25:20];
    case (opcode)
      OPC_LUI: begin
        dec.op  = op_lui;
        dec.imm = imm_u;
      end
      OPC_AUIPC: begin
        dec.op  = op_auipc;
        dec.imm = imm_u;
      end
      OPC_JAL: begin
        dec.op  = op_jal;
        dec.imm = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) dec.op = op_jalr;
        dec.imm = imm_i;
      end
      OPC_BRANCH: begin
        if (funct3 == 3'b001) dec.op = op_bne;  // only bne
        dec.imm = imm_b;
      end
      OPC_LOAD: begin
        case (funct3)
          3'b010:  dec.op = op_lw;
          3'b100:  dec.op = op_lbu;
          3'b011:  dec.op = op_ld;
          default: dec.op = op_illegal;
        endcase
        dec.imm = imm_i;
      end
      OPC_STORE: begin
        if (funct3 == 3'b011) dec.op = op_sd;  // only sd
        dec.imm = imm_s;
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) dec.op = op_addi;
        if (funct3 == 3'b011) dec.op = op_sltiu;
        if (funct3 == 3'b101 && funct7[6:1] == 6'b010000) dec.op = op_srai;  // shamt[5] in funct7[0]
        dec.imm = imm_i;
      end
      OPC_OP_IMM32: begin
        if (funct3 == 3'b000) dec.op = op_addiw;
        dec.imm = imm_i;
      end
      OPC_OP: begin
        if ({funct7, funct3} == 10'b0000000_000) dec.op = op_add;
        if ({funct7, funct3} == 10'b0100000_000) dec.op = op_sub;
      end
      OPC_OP32: begin
        if ({funct7, funct3} == 10'b0000000_000) dec.op = op_addw;
      end
      OPC_SYSTEM: begin
        if (inst == INST_EBREAK) dec.op = op_ebreak;  // whole word must match
      end
      default: dec.op = op_illegal;
    endcase
  end

endmodule

/* source/reg_file.sv */
// reg_file: 31 writable 64-bit registers, two combinational read ports, one write port
module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output xlen_t    rs1_data,
  output xlen_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  xlen_t    rd_data
);

  xlen_t regs [1:31];  // x0 has no storage

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // the controller is expected to filter x0 writes itself
  a_no_x0_write : assert property (@(posedge clk) disable iff (reset) !(we && rd == '0))
    else $error("register write enabled with rd = x0");

endmodule

/* source/alu.sv */
// alu: result computation, bne condition, jump targets and load/store addresses
module alu import rv_pkg::*; (
  input  decoded_t dec,
  input  xlen_t    pc,
  input  xlen_t    src1,
  input  xlen_t    src2,
  output xlen_t    result,
  output logic     taken,
  output xlen_t    mem_addr
);

  xlen_t       sum_imm;
  logic [31:0] word_sum;

  assign sum_imm  = src1 + dec.imm;
  // addw uses rs2, addiw the immediate
  assign word_sum = src1[31:0] + ((dec.op == op_addw) ? src2[31:0] : dec.imm[31:0]);

  always_comb begin
    case (dec.op)
      op_lui:             result = dec.imm;
      op_auipc:           result = pc + dec.imm;
      op_jal, op_jalr:    result = pc + 64'd4;  // link value
      op_addi:            result = sum_imm;
      op_sltiu:           result = {63'b0, src1 < dec.imm};  // unsigned compare
      op_addiw, op_addw:  result = {{32{word_sum[31]}}, word_sum};
      op_add:             result = src1 + src2;
      op_sub:             result = src1 - src2;
      op_srai:            result = $signed(src1) >>> dec.shamt;
      default:            result = '0;
    endcase
  end

  assign taken = (dec.op == op_bne) && (src1 != src2);

  // one address output serves both control transfer and memory
  always_comb begin
    case (dec.op)
      op_jal, op_bne: mem_addr = pc + dec.imm;
      op_jalr:        mem_addr = {sum_imm[63:1], 1'b0};
      default:        mem_addr = sum_imm;  // loads and sd
    endcase
  end

endmodule

/* source/bus_port.sv */
// bus_port: four-phase req/ack master with read-data capture and done pulse
module bus_port #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  output logic              req,
  input  logic              ack,
  input  logic [DATA_W-1:0] rdata_in,
  output logic [DATA_W-1:0] rdata,
  output logic              done
);

  typedef enum logic [1:0] {bp_idle, bp_wait_ack, bp_wait_release} bp_state_e;

  bp_state_e state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= bp_idle;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;  // single-cycle pulse
      case (state)
        bp_idle:         if (start) state <= bp_wait_ack;
        bp_wait_ack:     if (ack) state <= bp_wait_release;
        bp_wait_release: if (!ack) begin
          state <= bp_idle;
          done  <= 1'b1;
        end
        default:         state <= bp_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == bp_wait_ack && ack) rdata <= rdata_in;  // capture with ack
  end

  assign req = (state == bp_wait_ack);

  a_start_idle : assert property (@(posedge clk) disable iff (reset) start |-> state == bp_idle)
    else $error("start while port busy");
  a_req_hold : assert property (@(posedge clk) disable iff (reset) $fell(req) |-> $past(ack))
    else $error("req dropped before ack");

endmodule

/* source/core_ctrl.sv */
// core_ctrl: pc, instruction register, multi-cycle FSM, load alignment, store command, write-back
module core_ctrl import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  decoded_t dec,
  input  xlen_t    alu_result,
  input  xlen_t    alu_addr,
  input  logic     taken,
  input  xlen_t    rs2_data,
  output inst_t    inst,
  output xlen_t    pc,
  output logic     fetch_start,
  input  logic     fetch_done,
  input  inst_t    fetch_data,
  output logic     mem_start,
  output mem_req_t mem_cmd,
  input  logic     mem_done,
  input  xlen_t    mem_data,
  output logic     rf_we,
  output reg_idx_t rf_rd,
  output xlen_t    rf_wdata,
  output logic     halted,
  output logic     illegal
);

  ctrl_state_e state;
  logic        is_load;
  logic        is_mem;
  xlen_t       load_shifted;
  xlen_t       load_value;
  xlen_t       next_pc;

  assign is_load = (dec.op == op_lw) || (dec.op == op_lbu) || (dec.op == op_ld);
  assign is_mem  = is_load || (dec.op == op_sd);

  // bring the addressed word or byte down to bit 0
  assign load_shifted = mem_data >> {alu_addr[2:0], 3'b000};

  always_comb begin
    case (dec.op)
      op_lw:   load_value = {{32{load_shifted[31]}}, load_shifted[31:0]};
      op_lbu:  load_value = {56'b0, load_shifted[7:0]};
      default: load_value = mem_data;  // ld
    endcase
  end

  assign next_pc = (dec.op == op_jal || dec.op == op_jalr || taken) ? alu_addr : pc + 64'd4;

  assign rf_rd    = dec.rd;
  assign rf_wdata = is_load ? load_value : alu_result;
  assign rf_we    = (state == st_writeback) && dec.op != op_bne && dec.op != op_sd &&
                    dec.rd != '0;  // x0 never written

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= st_fetch;
      pc          <= RESET_PC;
      fetch_start <= 1'b1;  // first fetch starts right out of reset
      mem_start   <= 1'b0;
      halted      <= 1'b0;
      illegal     <= 1'b0;
    end else begin
      fetch_start <= 1'b0;
      mem_start   <= 1'b0;
      case (state)
        st_fetch: if (fetch_done) begin
          inst  <= fetch_data;
          state <= st_execute;
        end
        st_execute: begin
          if (dec.op == op_ebreak || dec.op == op_illegal) begin
            state   <= st_halt;
            halted  <= 1'b1;
            illegal <= (dec.op == op_illegal);
          end else if (is_mem) begin
            state     <= st_memory;
            mem_start <= 1'b1;
          end else begin
            state <= st_writeback;
          end
        end
        st_memory: if (mem_done) state <= st_writeback;
        st_writeback: begin
          pc          <= next_pc;
          state       <= st_fetch;
          fetch_start <= 1'b1;
        end
        default: state <= st_halt;  // halt holds forever
      endcase
    end
  end

  // store command, held while the data port is busy
  always_ff @(posedge clk) begin
    if (state == st_execute && is_mem) begin
      mem_cmd.addr  <= {alu_addr[63:3], 3'b000};
      mem_cmd.wdata <= rs2_data;
      mem_cmd.wstrb <= (dec.op == op_sd) ? 8'hff : 8'h00;
      mem_cmd.write <= (dec.op == op_sd);
    end
  end

  a_mem_only_ldst : assert property (@(posedge clk) disable iff (reset)
    mem_start |-> is_mem && state == st_memory)
    else $error("data access issued for a non-memory op");

endmodule

/* source/rv_core.sv */
// rv_core: top level of the multi-cycle core with instruction and data bus ports
module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     reset,
  output logic     ifetch_req,
  output xlen_t    ifetch_addr,
  input  logic     ifetch_ack,
  input  inst_t    ifetch_rdata,
  output logic     dmem_req,
  output mem_req_t dmem_cmd,
  input  logic     dmem_ack,
  input  xlen_t    dmem_rdata,
  output logic     halted,
  output logic     illegal
);

  decoded_t dec;
  inst_t    inst;
  inst_t    fetch_data;
  xlen_t    pc;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  xlen_t    alu_result;
  xlen_t    alu_addr;
  xlen_t    mem_data;
  xlen_t    rf_wdata;
  reg_idx_t rf_rd;
  logic     taken;
  logic     fetch_start;
  logic     fetch_done;
  logic     mem_start;
  logic     mem_done;
  logic     rf_we;

  assign ifetch_addr = pc;  // pc is stable through the fetch

  core_ctrl u_ctrl (
    .clk, .reset, .dec, .alu_result, .alu_addr, .taken, .rs2_data, .inst, .pc,
    .fetch_start, .fetch_done, .fetch_data, .mem_start, .mem_cmd(dmem_cmd), .mem_done,
    .mem_data, .rf_we, .rf_rd, .rf_wdata, .halted, .illegal
  );

  inst_decode u_decode (.inst, .dec);

  reg_file u_rf (
    .clk, .reset, .rs1(dec.rs1), .rs2(dec.rs2), .rs1_data, .rs2_data,
    .we(rf_we), .rd(rf_rd), .rd_data(rf_wdata)
  );

  alu u_alu (
    .dec, .pc, .src1(rs1_data), .src2(rs2_data), .result(alu_result), .taken,
    .mem_addr(alu_addr)
  );

  bus_port #(.DATA_W(32)) u_ifetch_port (
    .clk, .reset, .start(fetch_start), .req(ifetch_req), .ack(ifetch_ack),
    .rdata_in(ifetch_rdata), .rdata(fetch_data), .done(fetch_done)
  );

  bus_port #(.DATA_W(64)) u_dmem_port (
    .clk, .reset, .start(mem_start), .req(dmem_req), .ack(dmem_ack),
    .rdata_in(dmem_rdata), .rdata(mem_data), .done(mem_done)
  );

endmodule

/* dv/tb_tests.svh */
// instruction encoders, program loading, store-log check and directed tests
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

function automatic inst_t itype(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                reg_idx_t rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic inst_t rtype(logic [6:0] opc, logic [6:0] f7, logic [2:0] f3,
                                reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic inst_t utype(logic [6:0] opc, reg_idx_t rd, logic [19:0] imm);
  return {imm, rd, opc};
endfunction

function automatic inst_t sd_at(reg_idx_t rs2, logic [11:0] off);  // sd rs2, off(x0)
  return {off[11:5], rs2, 5'd0, 3'b011, off[4:0], OPC_STORE};
endfunction

function automatic inst_t bne_by(reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, 3'b001, off[4:1], off[11], OPC_BRANCH};
endfunction

function automatic inst_t jal_by(reg_idx_t rd, logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
endfunction

function automatic xlen_t sign_ext_word(logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

task automatic clear_memory();
  imem.delete();
  dmem.delete();
  log_addr.delete();
  log_data.delete();
  log_strb.delete();
  exp_q.delete();
  load_pc = RESET_PC;
  store_off = 12'h400;
endtask

task automatic emit(input inst_t w);
  imem[load_pc] = w;
  load_pc = load_pc + 64'd4;
endtask

// sd to the next result slot and note the value it must carry
task automatic emit_store(input reg_idx_t rs, input xlen_t expected);
  emit(sd_at(rs, store_off));
  store_off = store_off + 12'd8;
  exp_q.push_back(expected);
endtask

task automatic pulse_reset();
  @(negedge clk);
  reset = 1'b1;
  repeat (2) @(negedge clk);
  reset = 1'b0;
endtask

task automatic run_program();
  pulse_reset();
  while (!halted) @(negedge clk);
endtask

task automatic check_stores();
  check_eq("store count", 64'(log_addr.size()), 64'(exp_q.size()));
  for (int i = 0; i < exp_q.size() && i < log_addr.size(); i++) begin
    check_eq($sformatf("store %0d addr", i), log_addr[i], 64'h400 + 64'(8 * i));
    check_eq($sformatf("store %0d data", i), log_data[i], exp_q[i]);
    check_eq($sformatf("store %0d strobes", i), {56'b0, log_strb[i]}, 64'hff);
  end
endtask

task automatic arith_ops();
  xlen_t r [12];
  r[2] = {32'hffff_ffff, 20'h80000, 12'h000};
  r[3] = sign_ext_word(r[2][31:0] + 32'hffff_ffff);  // wraps below bit 31
  r[4] = sign_ext_word(r[3][31:0] + 32'd1);
  r[5] = sign_ext_word(r[3][31:0] + r[3][31:0]);
  r[1] = 64'd100;
  r[6] = r[1] - 64'd300;
  r[7] = r[3] + r[3];
  r[8] = r[1] - r[3];
  r[9] = (r[1] < 64'd200) ? 64'd1 : 64'd0;
  r[10] = (r[1] < 64'd50) ? 64'd1 : 64'd0;
  r[11] = xlen_t'($signed(r[6]) >>> 3);
  clear_memory();
  emit(utype(OPC_LUI, 5'd2, 20'h80000));
  emit(itype(OPC_OP_IMM32, 3'b000, 5'd3, 5'd2, -12'sd1));  // addiw
  emit(itype(OPC_OP_IMM32, 3'b000, 5'd4, 5'd3, 12'd1));
  emit(rtype(OPC_OP32, 7'b0000000, 3'b000, 5'd5, 5'd3, 5'd3));  // addw
  emit(itype(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd100));
  emit(itype(OPC_OP_IMM, 3'b000, 5'd6, 5'd1, -12'sd300));
  emit(rtype(OPC_OP, 7'b0000000, 3'b000, 5'd7, 5'd3, 5'd3));  // add
  emit(rtype(OPC_OP, 7'b0100000, 3'b000, 5'd8, 5'd1, 5'd3));  // sub
  emit(itype(OPC_OP_IMM, 3'b011, 5'd9, 5'd1, 12'd200));  // sltiu
  emit(itype(OPC_OP_IMM, 3'b011, 5'd10, 5'd1, 12'd50));
  emit(itype(OPC_OP_IMM, 3'b101, 5'd11, 5'd6, 12'h403));  // srai by 3
  for (int i = 3; i <= 11; i++) emit_store(reg_idx_t'(i), r[i]);
  emit(INST_EBREAK);
  run_program();
  check_stores();
endtask

task automatic control_transfer();
  xlen_t auipc_pc;
  xlen_t jal_pc;
  xlen_t jalr_pc;
  clear_memory();
  emit(utype(OPC_LUI, 5'd1, 20'h12345));
  emit(utype(OPC_LUI, 5'd2, 20'hfedcb));
  auipc_pc = load_pc;
  emit(utype(OPC_AUIPC, 5'd3, 20'h00001));
  jal_pc = load_pc;
  emit(jal_by(5'd4, 21'd12));  // lands on the addi below
  emit(sd_at(5'd1, 12'h7f8));  // jumped over
  emit(sd_at(5'd2, 12'h7f8));
  emit(itype(OPC_OP_IMM, 3'b000, 5'd5, 5'd0, 12'd41));  // odd so bit 0 gets cleared
  jalr_pc = load_pc;
  emit(itype(OPC_JALR, 3'b000, 5'd6, 5'd5, 12'd0));  // to 40
  emit(sd_at(5'd1, 12'h7f8));
  emit(sd_at(5'd2, 12'h7f8));
  emit_store(5'd1, {32'h0, 20'h12345, 12'h000});
  emit_store(5'd2, {32'hffff_ffff, 20'hfedcb, 12'h000});
  emit_store(5'd3, auipc_pc + 64'h1000);
  emit_store(5'd4, jal_pc + 64'd4);
  emit_store(5'd6, jalr_pc + 64'd4);
  emit(INST_EBREAK);
  run_program();
  check_stores();
endtask

task automatic load_forms();
  xlen_t d0;
  xlen_t d1;
  d0 = 64'h8765_4321_fedc_ba98;  // both words negative
  d1 = 64'h0123_4567_89ab_cdef;
  clear_memory();
  dmem[64'h600] = d0;
  dmem[64'h608] = d1;
  emit(itype(OPC_LOAD, 3'b011, 5'd1, 5'd0, 12'h600));  // ld
  emit(itype(OPC_LOAD, 3'b010, 5'd2, 5'd0, 12'h600));  // lw of the low word
  emit(itype(OPC_LOAD, 3'b010, 5'd3, 5'd0, 12'h604));  // lw of the high word
  emit(itype(OPC_LOAD, 3'b100, 5'd4, 5'd0, 12'h603));  // lbu
  emit(itype(OPC_LOAD, 3'b100, 5'd5, 5'd0, 12'h608));
  emit(itype(OPC_LOAD, 3'b100, 5'd6, 5'd0, 12'h60d));
  emit(itype(OPC_LOAD, 3'b100, 5'd7, 5'd0, 12'h60f));
  emit_store(5'd1, d0);
  emit_store(5'd2, sign_ext_word(d0[31:0]));
  emit_store(5'd3, sign_ext_word(d0[63:32]));
  emit_store(5'd4, {56'b0, d0[31:24]});
  emit_store(5'd5, {56'b0, d1[7:0]});
  emit_store(5'd6, {56'b0, d1[47:40]});
  emit_store(5'd7, {56'b0, d1[63:56]});
  emit(INST_EBREAK);
  run_program();
  check_stores();
endtask

task automatic branch_paths();
  clear_memory();
  emit(itype(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd5));
  emit(itype(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, 12'd5));
  emit(itype(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 12'd7));
  emit(bne_by(5'd1, 5'd2, 13'd8));  // equal so it falls through
  emit(itype(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 12'h011));
  emit_store(5'd10, 64'h11);
  emit(bne_by(5'd1, 5'd3, 13'd12));  // differ so it skips two
  emit(itype(OPC_OP_IMM, 3'b000, 5'd11, 5'd0, 12'h022));
  emit(sd_at(5'd11, 12'h7f8));
  emit(itype(OPC_OP_IMM, 3'b000, 5'd12, 5'd0, 12'h033));
  emit_store(5'd12, 64'h33);
  emit(itype(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, 12'd99));  // writes to x0 are dropped
  emit(rtype(OPC_OP, 7'b0000000, 3'b000, 5'd0, 5'd1, 5'd3));
  emit_store(5'd0, 64'h0);
  emit(INST_EBREAK);
  run_program();
  check_stores();
endtask

task automatic halt_states();
  clear_memory();
  emit(itype(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd1));
  emit_store(5'd1, 64'd1);
  emit(INST_EBREAK);
  emit(sd_at(5'd1, 12'h7f8));  // past the ebreak
  run_program();
  repeat (10) begin
    @(negedge clk);
    check_eq("ifetch_req while halted", {63'b0, ifetch_req}, 64'd0);
  end
  check_eq("halted after ebreak", {63'b0, halted}, 64'd1);  // must stay high
  check_eq("illegal after ebreak", {63'b0, illegal}, 64'd0);
  check_stores();
  clear_memory();
  emit(itype(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 12'd3));
  emit_store(5'd1, 64'd3);
  emit(rtype(OPC_OP, 7'b0000000, 3'b110, 5'd5, 5'd1, 5'd1));  // or is not supported
  emit(sd_at(5'd5, 12'h7f8));
  emit(INST_EBREAK);
  run_program();
  repeat (10) @(negedge clk);
  check_eq("halted after bad encoding", {63'b0, halted}, 64'd1);
  check_eq("illegal after bad encoding", {63'b0, illegal}, 64'd1);
  check_stores();
endtask

`endif

/* dv/tb_rv_core.sv */
// tb_rv_core: clock, reset, memory models for both ports, handshake monitor, checks, timeout
module tb_rv_core import rv_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 5000;  // ~120 instructions x 20 cycles, x2 margin
  localparam int PAY_W = $bits(mem_req_t);

  typedef logic [PAY_W-1:0] payload_t;

  logic     clk;
  logic     reset;
  logic     ifetch_req;
  xlen_t    ifetch_addr;
  logic     ifetch_ack;
  inst_t    ifetch_rdata;
  logic     dmem_req;
  mem_req_t dmem_cmd;
  logic     dmem_ack;
  xlen_t    dmem_rdata;
  logic     halted;
  logic     illegal;

  inst_t       imem [xlen_t];
  xlen_t       dmem [xlen_t];
  xlen_t       log_addr [$];  // one entry per sd seen on the data port
  xlen_t       log_data [$];
  strb_t       log_strb [$];
  xlen_t       exp_q [$];
  xlen_t       load_pc;
  logic [11:0] store_off;
  int          seed;
  int          errors;
  int          checks;
  int          cycles;
  int          i_cnt;  // remaining ack delay, -1 when not counting
  int          d_cnt;
  logic        prev_i_req;
  logic        prev_d_req;
  payload_t    prev_i_pay;
  payload_t    prev_d_pay;

  rv_core u_dut (
    .clk, .reset, .ifetch_req, .ifetch_addr, .ifetch_ack, .ifetch_rdata,
    .dmem_req, .dmem_cmd, .dmem_ack, .dmem_rdata, .halted, .illegal
  );

  always #2 clk = ~clk;

  task automatic check_eq(input string what, input xlen_t got, input xlen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic int ack_delay();
    return int'({$random(seed)} % 4);  // 0 to 3 cycles
  endfunction

  function automatic inst_t inst_read(xlen_t a);
    logic [31:0] fold;
    fold = a[63:32] ^ a[31:0];
    if (imem.exists(a)) return imem[a];
    return {fold[31:7] ^ {18'b0, fold[6:0]}, 7'b0000000};  // opcode 0 is illegal
  endfunction

  function automatic xlen_t data_read(xlen_t a);
    if (dmem.exists(a)) return dmem[a];
    return a ^ 64'ha5a5_5a5a_c3c3_3c3c;
  endfunction

  task automatic data_write(input mem_req_t c);
    xlen_t v;
    v = data_read(c.addr);
    for (int b = 0; b < 8; b++) begin
      if (c.wstrb[b]) v[8*b +: 8] = c.wdata[8*b +: 8];
    end
    dmem[c.addr] = v;
    log_addr.push_back(c.addr);
    log_data.push_back(c.wdata);
    log_strb.push_back(c.wstrb);
  endtask

  // instruction slave
  always @(negedge clk) begin
    if (reset) begin
      ifetch_ack = 1'b0;
      i_cnt = -1;
    end else if (ifetch_ack) begin
      if (!ifetch_req) ifetch_ack = 1'b0;  // release after req drops
    end else if (ifetch_req) begin
      if (i_cnt < 0) i_cnt = ack_delay();
      if (i_cnt == 0) begin
        ifetch_rdata = inst_read(ifetch_addr);
        ifetch_ack = 1'b1;
      end
      i_cnt = i_cnt - 1;
    end
  end

  // data slave
  always @(negedge clk) begin
    if (reset) begin
      dmem_ack = 1'b0;
      d_cnt = -1;
    end else if (dmem_ack) begin
      if (!dmem_req) dmem_ack = 1'b0;
    end else if (dmem_req) begin
      if (d_cnt < 0) d_cnt = ack_delay();
      if (d_cnt == 0) begin
        if (dmem_cmd.write) data_write(dmem_cmd);
        else dmem_rdata = data_read(dmem_cmd.addr);
        dmem_ack = 1'b1;
      end
      d_cnt = d_cnt - 1;
    end
  end

  task automatic watch_port(input string name, input logic req, input logic ack,
                            input logic last_req, input payload_t pay,
                            input payload_t last_pay);
    if (req && !last_req && ack) begin
      errors++;
      $display("%0t: %s req rose while ack was still high", $time, name);
    end
    if (!req && last_req && !ack) begin
      errors++;
      $display("%0t: %s req dropped before ack", $time, name);
    end
    if (req && last_req && pay != last_pay) begin
      errors++;
      $display("%0t: %s address or command changed while req was high", $time, name);
    end
  endtask

  // protocol monitor, samples just after the rising edge
  always @(posedge clk) begin
    #1;
    if (reset) begin
      prev_i_req = 1'b0;
      prev_d_req = 1'b0;
    end else begin
      watch_port("ifetch", ifetch_req, ifetch_ack, prev_i_req,
                 {{(PAY_W - 64){1'b0}}, ifetch_addr}, prev_i_pay);
      watch_port("dmem", dmem_req, dmem_ack, prev_d_req, dmem_cmd, prev_d_pay);
      if (halted && ifetch_req) begin
        errors++;
        $display("%0t: instruction fetch requested after halt", $time);
      end
      prev_i_req = ifetch_req;
      prev_d_req = dmem_req;
      prev_i_pay = {{(PAY_W - 64){1'b0}}, ifetch_addr};
      prev_d_pay = dmem_cmd;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  `include "tb_tests.svh"

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    ifetch_ack = 1'b0;
    ifetch_rdata = '0;
    dmem_ack = 1'b0;
    dmem_rdata = '0;
    seed = 92266;
    errors = 0;
    checks = 0;
    cycles = 0;
    i_cnt = -1;
    d_cnt = -1;
    arith_ops();
    control_transfer();
    load_forms();
    branch_paths();
    halt_states();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* rv_core.f */
+incdir+dv
source/rv_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/alu.sv
source/bus_port.sv
source/core_ctrl.sv
source/rv_core.sv
dv/tb_rv_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_rv_core
FILELIST  = rv_core.f
LOG       = sim.log
PASS_MSG  = Done: no errors
FAIL_MSG  = Done: errors found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
